/* bram_test_pkg.sv */
`default_nettype none

package bram_test_pkg;

    // host side
    localparam int apb_addr_w = 5;
    localparam int data_w     = 32;

    // address register covers the deepest memory
    localparam int mem_addr_w = 11;

    // 16 Kbit per memory
    localparam int depth8  = 2048;
    localparam int depth16 = 1024;
    localparam int depth32 = 512;

    // width select, code 3 is rejected by the register file
    typedef enum logic [1:0] {
        sel8  = 2'd0,
        sel16 = 2'd1,
        sel32 = 2'd2
    } width_sel_t;

    // register offsets
    localparam logic [apb_addr_w-1:0] reg_ctrl  = 5'h00;
    localparam logic [apb_addr_w-1:0] reg_addr  = 5'h04;
    localparam logic [apb_addr_w-1:0] reg_wdata = 5'h08;
    localparam logic [apb_addr_w-1:0] reg_cmd   = 5'h0C;
    localparam logic [apb_addr_w-1:0] reg_rdata = 5'h10;

    // power-up test patterns, one byte per word, repeated across the lanes
    localparam int preload_count = 10;
    localparam logic [7:0] preload_pattern [preload_count] = '{
        8'h01, 8'hAA, 8'h55, 8'hFF, 8'hF0,
        8'h0F, 8'hCC, 8'h33, 8'h02, 8'h04
    };

    // memory payloads
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] half_t;
    typedef logic [31:0] word_t;

endpackage

`default_nettype wire

/* sdp_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sdp_ram
    import bram_test_pkg::*;
#(
    parameter type payload_t = byte_t,
    parameter int depth = depth8,
    localparam int aw = $clog2(depth)
) (
    input  wire            rdclk,
    // write port
    input  wire            wren,
    input  wire [aw-1:0]   wraddr,
    input  wire payload_t  wdata,
    // read port
    input  wire            rden,
    input  wire [aw-1:0]   rdaddr,
    output payload_t       rdata
);

    localparam int lanes = $bits(payload_t) / 8;

    payload_t mem [depth];

    // words 0..9 carry the pattern byte in every lane and the rest start cleared
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
        for (int k = 0; k < preload_count; k++) begin
            mem[k] = {lanes{preload_pattern[k]}};
        end
    end

    always @(posedge rdclk) begin
        if (wren) begin
            mem[wraddr] <= wdata;
        end
    end

    // read data registered one cycle after the address
    always_ff @(posedge rdclk) begin
        if (rden) begin
            rdata <= mem[rdaddr];
        end
    end

    a_wraddr_range: assert property (
        @(posedge rdclk) wren |-> (!$isunknown(wraddr) && (int'(wraddr) < depth))
    ) else $error("sdp_ram write address %0d invalid for depth %0d", wraddr, depth);

endmodule

`default_nettype wire

/* ram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_bank
    import bram_test_pkg::*;
(
    input  wire                   rdclk,
    input  wire                   rst_n,
    input  wire width_sel_t       sel,
    input  wire [mem_addr_w-1:0]  addr,
    input  wire [data_w-1:0]      wdata,
    input  wire                   wr_stb,
    output logic [data_w-1:0]     rdata
);

    localparam int aw8  = $clog2(depth8);
    localparam int aw16 = $clog2(depth16);
    localparam int aw32 = $clog2(depth32);

    logic       wren8;
    logic       wren16;
    logic       wren32;
    byte_t      rd8;
    half_t      rd16;
    word_t      rd32;
    width_sel_t sel_q;

    // only the selected memory sees the strobe
    assign wren8  = wr_stb && (sel == sel8);
    assign wren16 = wr_stb && (sel == sel16);
    assign wren32 = wr_stb && (sel == sel32);

    sdp_ram #(
        .payload_t (byte_t),
        .depth     (depth8)
    ) mem8 (
        .rdclk  (rdclk),
        .wren   (wren8),
        .wraddr (addr[aw8-1:0]),
        .wdata  (wdata[$bits(byte_t)-1:0]),
        .rden   (1'b1),
        .rdaddr (addr[aw8-1:0]),
        .rdata  (rd8)
    );

    sdp_ram #(
        .payload_t (half_t),
        .depth     (depth16)
    ) mem16 (
        .rdclk  (rdclk),
        .wren   (wren16),
        .wraddr (addr[aw16-1:0]),
        .wdata  (wdata[$bits(half_t)-1:0]),
        .rden   (1'b1),
        .rdaddr (addr[aw16-1:0]),
        .rdata  (rd16)
    );

    sdp_ram #(
        .payload_t (word_t),
        .depth     (depth32)
    ) mem32 (
        .rdclk  (rdclk),
        .wren   (wren32),
        .wraddr (addr[aw32-1:0]),
        .wdata  (wdata[$bits(word_t)-1:0]),
        .rden   (1'b1),
        .rdaddr (addr[aw32-1:0]),
        .rdata  (rd32)
    );

    // select follows the memory read register by one cycle
    always_ff @(posedge rdclk) begin
        if (!rst_n) begin
            sel_q <= sel8;
        end else begin
            sel_q <= sel;
        end
    end

    always_comb begin
        case (sel_q)
            sel8:    rdata = data_w'(rd8);
            sel16:   rdata = data_w'(rd16);
            sel32:   rdata = data_w'(rd32);
            default: rdata = '0;
        endcase
    end

    // every strobe lands in exactly one memory
    a_wren_onehot: assert property (
        @(posedge rdclk) disable iff (!rst_n)
        wr_stb |-> $onehot({wren8, wren16, wren32})
    ) else $error("ram_bank write strobe did not reach exactly one memory");

    // register file must never pass the reserved width code
    a_sel_legal: assert property (
        @(posedge rdclk) disable iff (!rst_n)
        sel inside {sel8, sel16, sel32}
    ) else $error("ram_bank received reserved width code");

endmodule

`default_nettype wire

/* apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_regs
    import bram_test_pkg::*;
(
    input  wire                   rdclk,
    input  wire                   rst_n,
    // APB slave
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire [apb_addr_w-1:0]  paddr,
    input  wire [data_w-1:0]      pwdata,
    output logic [data_w-1:0]     prdata,
    output logic                  pready,
    output logic                  pslverr,
    // to the memory bank
    output width_sel_t            sel,
    output logic [mem_addr_w-1:0] addr,
    output logic [data_w-1:0]     wdata,
    output logic                  wr_stb,
    input  wire [data_w-1:0]      rdata
);

    logic access;
    logic rdata_rd;
    logic offset_ok;
    logic bad_code;
    logic ro_write;
    logic err;
    logic wr_fire;
    logic wait_q;

    assign access   = psel && penable;
    assign rdata_rd = (paddr == reg_rdata) && !pwrite;

    // error decode
    assign offset_ok = paddr inside {reg_ctrl, reg_addr, reg_wdata, reg_cmd, reg_rdata};
    assign bad_code  = pwrite && (paddr == reg_ctrl) && (pwdata[1:0] == 2'b11);
    assign ro_write  = pwrite && (paddr == reg_rdata);
    assign err       = !offset_ok || bad_code || ro_write;

    // memory read data needs one extra cycle
    assign pready  = !(access && rdata_rd) || wait_q;
    assign pslverr = access && pready && err;
    assign wr_fire = access && pready && pwrite && !err;

    // set in the first access cycle of a data read, cleared on completion
    always_ff @(posedge rdclk) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= access && rdata_rd && !wait_q;
        end
    end

    always_ff @(posedge rdclk) begin
        if (!rst_n) begin
            sel    <= sel8;
            addr   <= '0;
            wdata  <= '0;
            wr_stb <= 1'b0;
        end else begin
            // strobe lasts one cycle
            wr_stb <= 1'b0;
            if (wr_fire) begin
                case (paddr)
                    reg_ctrl:  sel    <= width_sel_t'(pwdata[1:0]);
                    reg_addr:  addr   <= pwdata[mem_addr_w-1:0];
                    reg_wdata: wdata  <= pwdata;
                    reg_cmd:   wr_stb <= 1'b1;
                    default:   ;
                endcase
            end
        end
    end

    // read mux, zero for write-only and unmapped offsets
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                reg_ctrl:  prdata = data_w'(sel);
                reg_addr:  prdata = data_w'(addr);
                reg_wdata: prdata = wdata;
                reg_rdata: prdata = rdata;
                default:   prdata = '0;
            endcase
        end
    end

    // host must hold the transfer through the wait state
    a_psel_held: assert property (
        @(posedge rdclk) disable iff (!rst_n)
        (psel && penable && !pready) |=> (psel && penable)
    ) else $error("apb_regs psel dropped before pready");

    a_ctrl_stable: assert property (
        @(posedge rdclk) disable iff (!rst_n)
        (psel && penable && !pready) |=> ($stable(paddr) && $stable(pwrite))
    ) else $error("apb_regs paddr or pwrite changed in access phase");

endmodule

`default_nettype wire

/* bram_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_test_top
    import bram_test_pkg::*;
(
    input  wire                   rdclk,
    input  wire                   rst_n,
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire [apb_addr_w-1:0]  paddr,
    input  wire [data_w-1:0]      pwdata,
    output logic [data_w-1:0]     prdata,
    output logic                  pready,
    output logic                  pslverr
);

    width_sel_t            sel;
    logic [mem_addr_w-1:0] addr;
    logic [data_w-1:0]     wdata;
    logic                  wr_stb;
    logic [data_w-1:0]     rdata;

    apb_regs u_regs (
        .rdclk   (rdclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .sel     (sel),
        .addr    (addr),
        .wdata   (wdata),
        .wr_stb  (wr_stb),
        .rdata   (rdata)
    );

    // three memories behind one address and data register
    ram_bank u_bank (
        .rdclk  (rdclk),
        .rst_n  (rst_n),
        .sel    (sel),
        .addr   (addr),
        .wdata  (wdata),
        .wr_stb (wr_stb),
        .rdata  (rdata)
    );

endmodule

`default_nettype wire

/* tb_bram_test.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bram_test
    import bram_test_pkg::*;
;

    localparam int reset_cycles = 4;
    localparam int rand_pairs   = 40;
    localparam logic ok  = 1'b0;
    localparam logic bad = 1'b1;

    logic                  rdclk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [data_w-1:0]     pwdata;
    logic [data_w-1:0]     prdata;
    logic                  pready;
    logic                  pslverr;

    // stimulus table with one entry per APB transfer
    string                 step_name [$];
    logic                  step_wr   [$];
    logic [apb_addr_w-1:0] step_off  [$];
    logic [data_w-1:0]     step_data [$];
    logic [data_w-1:0]     step_exp  [$];
    logic                  step_err  [$];
    logic                  table_ready;

    // reference state of the register file and the three memories
    logic [1:0]            sh_sel;
    logic [mem_addr_w-1:0] sh_addr;
    logic [data_w-1:0]     sh_wdata;
    logic [7:0]            model8  [depth8];
    logic [15:0]           model16 [depth16];
    logic [31:0]           model32 [depth32];
    logic [15:0]           lfsr;

    bram_test_top DUT (
        .rdclk   (rdclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 rdclk = ~rdclk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31:0] lane_mask(input logic [1:0] w, input logic [31:0] d);
        case (w)
            sel8:    return {24'h0, d[7:0]};
            sel16:   return {16'h0, d[15:0]};
            default: return d;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [1:0] w, input logic [10:0] a);
        case (w)
            sel8:    return {24'h0, model8[a]};
            sel16:   return {16'h0, model16[a[9:0]]};
            default: return model32[a[8:0]];
        endcase
    endfunction

    // pattern byte in every lane for words 0..9 and zero elsewhere
    task automatic init_model();
        for (int i = 0; i < depth8; i++) begin
            model8[i] = '0;
        end
        for (int i = 0; i < depth16; i++) begin
            model16[i] = '0;
        end
        for (int i = 0; i < depth32; i++) begin
            model32[i] = '0;
        end
        for (int k = 0; k < preload_count; k++) begin
            model8[k]  = preload_pattern[k];
            model16[k] = {2{preload_pattern[k]}};
            model32[k] = {4{preload_pattern[k]}};
        end
    endtask

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s pslverr expected %b actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "pslverr mismatch");
        end
    endtask

    task automatic check_waits(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s wait states expected %0d actual %0d", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "wait state mismatch");
        end
    endtask

    task automatic wr_step(input string name, input logic [4:0] off, input logic [31:0] data,
                           input logic err);
        step_name.push_back(name);
        step_wr.push_back(1'b1);
        step_off.push_back(off);
        step_data.push_back(data);
        step_exp.push_back(32'h0);
        step_err.push_back(err);
    endtask

    task automatic rd_step(input string name, input logic [4:0] off, input logic [31:0] exp,
                           input logic err);
        step_name.push_back(name);
        step_wr.push_back(1'b0);
        step_off.push_back(off);
        step_data.push_back(32'h0);
        step_exp.push_back(exp);
        step_err.push_back(err);
    endtask

    // starts 1 ns after a rising edge and samples at the falling edge
    task automatic apb_transfer(input logic wr, input logic [4:0] off, input logic [31:0] data,
                                output logic [31:0] rd, output logic err, output int waits);
        logic done;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = off;
        pwdata  = data;
        @(posedge rdclk);
        #1;
        penable = 1'b1;
        done  = 1'b0;
        waits = 0;
        while (!done) begin
            @(negedge rdclk);
            if (pready) begin
                rd   = prdata;
                err  = pslverr;
                done = 1'b1;
            end else begin
                waits++;
            end
            @(posedge rdclk);
            #1;
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_step(input string name, input logic wr, input logic [4:0] off,
                            input logic [31:0] data, input logic [31:0] exp, input logic err);
        logic [31:0] rd;
        logic        slverr;
        int          waits;
        apb_transfer(wr, off, data, rd, slverr, waits);
        check_err(name, err, slverr);
        // data reads take exactly one wait state
        check_waits(name, (!wr && off == reg_rdata) ? 1 : 0, waits);
        if (!wr) begin
            check_data(name, exp, rd);
        end
        // accepted writes move the reference state
        if (wr && !err) begin
            case (off)
                reg_ctrl:  sh_sel   = data[1:0];
                reg_addr:  sh_addr  = data[10:0];
                reg_wdata: sh_wdata = data;
                reg_cmd: begin
                    if (sh_sel == sel8) model8[sh_addr] = sh_wdata[7:0];
                    else if (sh_sel == sel16) model16[sh_addr[9:0]] = sh_wdata[15:0];
                    else model32[sh_addr[8:0]] = sh_wdata;
                end
                default: ;
            endcase
        end
    endtask

    task automatic build_table();
        for (int w = 0; w < 3; w++) begin
            wr_step($sformatf("preload sel %0d", w), reg_ctrl, 32'(w), ok);
            for (int a = 0; a <= preload_count; a++) begin
                wr_step($sformatf("preload w%0d a%0d", w, a), reg_addr, 32'(a), ok);
                rd_step($sformatf("preload w%0d a%0d", w, a), reg_rdata,
                        model_read(2'(w), 11'(a)), ok);
            end
        end
        wr_step("wr8 ctrl", reg_ctrl, 32'd0, ok);
        wr_step("wr8 addr", reg_addr, 32'd20, ok);
        wr_step("wr8 data", reg_wdata, 32'h12345678, ok);
        wr_step("wr8 cmd", reg_cmd, 32'h0, ok);
        rd_step("wr8 read", reg_rdata, 32'h00000078, ok);
        wr_step("wr16 ctrl", reg_ctrl, 32'd1, ok);
        wr_step("wr16 data", reg_wdata, 32'hCAFEBABE, ok);
        wr_step("wr16 cmd", reg_cmd, 32'h0, ok);
        rd_step("wr16 read", reg_rdata, 32'h0000BABE, ok);
        wr_step("wr32 ctrl", reg_ctrl, 32'd2, ok);
        wr_step("wr32 data", reg_wdata, 32'hDEADBEEF, ok);
        wr_step("wr32 cmd", reg_cmd, 32'h0, ok);
        rd_step("wr32 read", reg_rdata, 32'hDEADBEEF, ok);
        // 8-bit write at 30 must not reach the wider memories
        wr_step("iso sel8", reg_ctrl, 32'd0, ok);
        wr_step("iso addr", reg_addr, 32'd30, ok);
        wr_step("iso data", reg_wdata, 32'h000000A5, ok);
        wr_step("iso cmd", reg_cmd, 32'h0, ok);
        wr_step("iso sel16", reg_ctrl, 32'd1, ok);
        rd_step("iso read16", reg_rdata, 32'h0, ok);
        wr_step("iso sel32", reg_ctrl, 32'd2, ok);
        rd_step("iso read32", reg_rdata, 32'h0, ok);
        // 0x200 wraps to 0 on the 9-bit address of the 32-bit memory
        wr_step("alias addr0", reg_addr, 32'h0, ok);
        wr_step("alias data", reg_wdata, 32'h0BADF00D, ok);
        wr_step("alias cmd", reg_cmd, 32'h0, ok);
        wr_step("alias addr200", reg_addr, 32'h200, ok);
        rd_step("alias read", reg_rdata, 32'h0BADF00D, ok);
        wr_step("alias sel8", reg_ctrl, 32'd0, ok);
        rd_step("alias read8", reg_rdata, 32'h0, ok);
        wr_step("regs ctrl", reg_ctrl, 32'd1, ok);
        rd_step("regs ctrl rd", reg_ctrl, 32'd1, ok);
        wr_step("regs addr", reg_addr, 32'hFFFFF014, ok);
        rd_step("regs addr rd", reg_addr, 32'h014, ok);
        wr_step("regs wdata", reg_wdata, 32'hA5A55A5A, ok);
        rd_step("regs wdata rd", reg_wdata, 32'hA5A55A5A, ok);
        rd_step("regs cmd rd", reg_cmd, 32'h0, ok);
        wr_step("err unmapped wr", 5'h14, 32'hFFFFFFFF, bad);
        rd_step("err unmapped rd", 5'h1C, 32'h0, bad);
        wr_step("err rdata wr", reg_rdata, 32'h00005555, bad);
        wr_step("err code3", reg_ctrl, 32'd3, bad);
        rd_step("err ctrl kept", reg_ctrl, 32'd1, ok);
        rd_step("err addr kept", reg_addr, 32'h014, ok);
        rd_step("err wdata kept", reg_wdata, 32'hA5A55A5A, ok);
        rd_step("err mem kept", reg_rdata, 32'h0000BABE, ok);
    endtask

    task automatic random_pairs();
        logic [31:0] v;
        logic [1:0]  w;
        logic [10:0] a;
        logic [31:0] d;
        string       name;
        for (int i = 0; i < rand_pairs; i++) begin
            take_bits(2, v);
            w = (v[1:0] == 2'd3) ? 2'd2 : v[1:0];
            take_bits(11, v);
            a = v[10:0];
            take_bits(32, d);
            name = $sformatf("random %0d", i);
            run_step(name, 1'b1, reg_ctrl, {30'h0, w}, 32'h0, ok);
            run_step(name, 1'b1, reg_addr, {21'h0, a}, 32'h0, ok);
            run_step(name, 1'b0, reg_rdata, 32'h0, model_read(w, a), ok);
            run_step(name, 1'b1, reg_wdata, d, 32'h0, ok);
            run_step(name, 1'b1, reg_cmd, 32'h0, 32'h0, ok);
            run_step(name, 1'b0, reg_rdata, 32'h0, lane_mask(w, d), ok);
        end
    endtask

    initial begin
        wait (table_ready === 1'b1);
        repeat ((step_name.size() + rand_pairs) * 20 + reset_cycles) @(posedge rdclk);
        $display("run timed out before all tests completed");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rdclk       = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        sh_sel      = sel8;
        sh_addr     = '0;
        sh_wdata    = '0;
        lfsr        = 16'd169;
        table_ready = 1'b0;
        init_model();
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge rdclk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < step_name.size(); i++) begin
            run_step(step_name[i], step_wr[i], step_off[i], step_data[i], step_exp[i],
                     step_err[i]);
        end
        random_pairs();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* bram_test.f */
bram_test_pkg.sv
sdp_ram.sv
ram_bank.sv
apb_regs.sv
bram_test_top.sv
tb_bram_test.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, result in sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_bram_test -f bram_test.f -o sim_bram
	./obj_dir/sim_bram > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
